// ==== src/rs_syndrome_pkg.sv ====
`default_nettype none

package rs_syndrome_pkg;

   //--------------------------------------------------------------------------
   // field constants, GF(64)
   //--------------------------------------------------------------------------
   localparam int GF_WIDTH = 6;                    // bits per symbol

   // low bits of x^6+x^5+x^4+x+1, folded back in when bit 5 shifts out
   localparam logic [GF_WIDTH-1:0] GF_POLY = 6'h33;

   localparam int NUM_SYNDROMES = 20;              // powers 0 to 19

   //--------------------------------------------------------------------------
   // block constants
   //--------------------------------------------------------------------------
   localparam int CNT_WIDTH = 6;                   // position counter width

   localparam logic [CNT_WIDTH-1:0] BLOCK_LEN = 6'd54;  // symbols per block

endpackage : rs_syndrome_pkg

`default_nettype wire

// ==== src/block_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module block_counter (
   input  logic CLK,
   input  logic RESET,
   input  logic enable,                            // hold when low
   input  logic sync,                              // first symbol of block
   output logic done                               // last symbol absorbed
);

   //--------------------------------------------------------------------------
   // symbol position
   //--------------------------------------------------------------------------
   // 0 means idle, 1 to BLOCK_LEN is the symbol just absorbed
   logic [rs_syndrome_pkg::CNT_WIDTH-1:0] count;

   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         count <= '0;
      end
      else if (enable) begin
         if (sync) begin
            count <= rs_syndrome_pkg::CNT_WIDTH'(1);   // restart at symbol 1
         end
         else if ((count == '0) || (count == rs_syndrome_pkg::BLOCK_LEN)) begin
            count <= '0;                             // idle until next sync
         end
         else begin
            count <= count + 1'b1;
         end
      end
   end

   //--------------------------------------------------------------------------
   // done decode
   //--------------------------------------------------------------------------
   assign done = (count == rs_syndrome_pkg::BLOCK_LEN);

   //--------------------------------------------------------------------------
   // checks
   //--------------------------------------------------------------------------
   // position never runs past the end of a block
   a_count_range : assert property (
      @(posedge CLK) disable iff (!RESET)
      count <= rs_syndrome_pkg::BLOCK_LEN
   ) else $error("block_counter: count %0d beyond block length", count);

   // done is a single enabled beat unless a new block starts right away
   a_done_single : assert property (
      @(posedge CLK) disable iff (!RESET)
      (done && enable && !sync) |=> !done
   ) else $error("block_counter: done held past its enabled edge");

endmodule : block_counter

`default_nettype wire

// ==== src/syndrome_cell.sv ====
`timescale 1ns/1ns
`default_nettype none

module syndrome_cell #(
   parameter int POWER = 0                         // multiplier is alpha^POWER
) (
   input  logic                                 CLK,
   input  logic                                 RESET,
   input  logic                                 enable,
   input  logic                                 sync,
   input  logic [rs_syndrome_pkg::GF_WIDTH-1:0] data_in,
   output logic [rs_syndrome_pkg::GF_WIDTH-1:0] syndrome
);

   // alpha has order 63, so powers past 62 only repeat the field
   if ((POWER < 0) || (POWER > 62)) begin : g_power_check
      $error("syndrome_cell: POWER %0d outside 0 to 62", POWER);
   end

   //--------------------------------------------------------------------------
   // constant multiplier
   //--------------------------------------------------------------------------
   // one step of x * alpha, reduced by the field polynomial
   function automatic logic [rs_syndrome_pkg::GF_WIDTH-1:0] mul_alpha(
      input logic [rs_syndrome_pkg::GF_WIDTH-1:0] x
   );
      logic [rs_syndrome_pkg::GF_WIDTH-1:0] shifted;
      shifted = {x[rs_syndrome_pkg::GF_WIDTH-2:0], 1'b0};
      if (x[rs_syndrome_pkg::GF_WIDTH-1]) begin
         shifted = shifted ^ rs_syndrome_pkg::GF_POLY;   // fold top bit back
      end
      return shifted;
   endfunction

   logic [rs_syndrome_pkg::GF_WIDTH-1:0] product;  // syndrome * alpha^POWER

   // unrolled at elaboration, reduces to a small xor network
   always_comb begin
      product = syndrome;
      for (int k = 0; k < POWER; k++) begin
         product = mul_alpha(product);
      end
   end

   //--------------------------------------------------------------------------
   // Horner accumulator
   //--------------------------------------------------------------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         syndrome <= '0;
      end
      else if (enable) begin
         if (sync) begin
            syndrome <= data_in;                     // first symbol of block
         end
         else begin
            syndrome <= data_in ^ product;           // acc * alpha^POWER + r
         end
      end
   end

   //--------------------------------------------------------------------------
   // checks
   //--------------------------------------------------------------------------
   // the block always starts from the symbol seen with sync
   a_sync_load : assert property (
      @(posedge CLK) disable iff (!RESET)
      (enable && sync) |=> (syndrome == $past(data_in))
   ) else $error("syndrome_cell %0d: sync did not load data_in", POWER);

endmodule : syndrome_cell

`default_nettype wire

// ==== src/rs_syndrome.sv ====
`timescale 1ns/1ns
`default_nettype none

module rs_syndrome (
   input  logic                                 CLK,
   input  logic                                 RESET,
   input  logic                                 enable,   // stall when low
   input  logic                                 sync,     // marks symbol 1
   input  logic [rs_syndrome_pkg::GF_WIDTH-1:0] data_in,  // received symbol

   // S_i = r(alpha^i), valid while done is high
   output logic [rs_syndrome_pkg::GF_WIDTH-1:0] syndromes [rs_syndrome_pkg::NUM_SYNDROMES],
   output logic                                 done
);

   //--------------------------------------------------------------------------
   // block position
   //--------------------------------------------------------------------------
   block_counter u_block_counter (
      .CLK    (CLK),
      .RESET  (RESET),
      .enable (enable),
      .sync   (sync),
      .done   (done)
   );

   //--------------------------------------------------------------------------
   // syndrome cells
   //--------------------------------------------------------------------------
   // cell i evaluates the received polynomial at alpha^i
   for (genvar i = 0; i < rs_syndrome_pkg::NUM_SYNDROMES; i++) begin : g_cell
      syndrome_cell #(
         .POWER (i)
      ) u_syndrome_cell (
         .CLK      (CLK),
         .RESET    (RESET),
         .enable   (enable),
         .sync     (sync),
         .data_in  (data_in),
         .syndrome (syndromes[i])              // straight from the register
      );
   end

endmodule : rs_syndrome

`default_nettype wire

// ==== include/syndrome_model.svh ====
`ifndef SYNDROME_MODEL_SVH
`define SYNDROME_MODEL_SVH

//----------------------------------------------------------------------------
// GF(64) arithmetic
//----------------------------------------------------------------------------
// x * alpha, reduced by the field polynomial
function automatic logic [rs_syndrome_pkg::GF_WIDTH-1:0] gf_mul_alpha(
   input logic [rs_syndrome_pkg::GF_WIDTH-1:0] x
);
   logic [rs_syndrome_pkg::GF_WIDTH-1:0] y;
   y = {x[rs_syndrome_pkg::GF_WIDTH-2:0], 1'b0};
   if (x[rs_syndrome_pkg::GF_WIDTH-1]) begin
      y = y ^ rs_syndrome_pkg::GF_POLY;
   end
   return y;
endfunction

// general product, shift and add from the top bit of b
function automatic logic [rs_syndrome_pkg::GF_WIDTH-1:0] gf_mul(
   input logic [rs_syndrome_pkg::GF_WIDTH-1:0] a,
   input logic [rs_syndrome_pkg::GF_WIDTH-1:0] b
);
   logic [rs_syndrome_pkg::GF_WIDTH-1:0] p;
   p = '0;
   for (int k = rs_syndrome_pkg::GF_WIDTH - 1; k >= 0; k--) begin
      p = gf_mul_alpha(p);
      if (b[k]) begin
         p = p ^ a;
      end
   end
   return p;
endfunction

// alpha^n, any n >= 0
function automatic logic [rs_syndrome_pkg::GF_WIDTH-1:0] gf_alpha_pow(input int n);
   logic [rs_syndrome_pkg::GF_WIDTH-1:0] p;
   p = rs_syndrome_pkg::GF_WIDTH'(1);
   for (int k = 0; k < (n % 63); k++) begin
      p = gf_mul_alpha(p);
   end
   return p;
endfunction

//----------------------------------------------------------------------------
// reference syndromes
//----------------------------------------------------------------------------
// Horner over one block, symbol 0 first, S_i = sum r_j * alpha^(i*(53-j))
function automatic void model_syndromes(
   input  logic [rs_syndrome_pkg::GF_WIDTH-1:0] block [rs_syndrome_pkg::BLOCK_LEN],
   output logic [rs_syndrome_pkg::GF_WIDTH-1:0] synd  [rs_syndrome_pkg::NUM_SYNDROMES]
);
   logic [rs_syndrome_pkg::GF_WIDTH-1:0] acc;
   logic [rs_syndrome_pkg::GF_WIDTH-1:0] a_i;
   for (int i = 0; i < rs_syndrome_pkg::NUM_SYNDROMES; i++) begin
      a_i = gf_alpha_pow(i);
      acc = '0;
      for (int j = 0; j < rs_syndrome_pkg::BLOCK_LEN; j++) begin
         acc = gf_mul(acc, a_i) ^ block[j];
      end
      synd[i] = acc;
   end
endfunction

`endif

// ==== testbench/tb_rs_syndrome.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rs_syndrome;

   `include "syndrome_model.svh"

   logic                                 CLK;
   logic                                 RESET;
   logic                                 enable;
   logic                                 sync;
   logic [rs_syndrome_pkg::GF_WIDTH-1:0] data_in;
   logic [rs_syndrome_pkg::GF_WIDTH-1:0] syndromes [rs_syndrome_pkg::NUM_SYNDROMES];
   logic                                 done;

   integer seed;
   int     err_count;                              // value mismatches
   int     fail_count;                             // timeouts and late done

   logic [rs_syndrome_pkg::GF_WIDTH-1:0] block    [rs_syndrome_pkg::BLOCK_LEN];
   logic [rs_syndrome_pkg::GF_WIDTH-1:0] expected [rs_syndrome_pkg::NUM_SYNDROMES];

   rs_syndrome dut (
      .CLK       (CLK),
      .RESET     (RESET),
      .enable    (enable),
      .sync      (sync),
      .data_in   (data_in),
      .syndromes (syndromes),
      .done      (done)
   );

   initial begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK;                      // 100 ns period
   end

   //--------------------------------------------------------------------------
   // checking helpers
   //--------------------------------------------------------------------------
   task automatic check_done_low(input int absorbed);
      if (done !== 1'b0) begin
         $display("ERR t=%0t done expected 0 got %b after %0d symbols",
                  $time, done, absorbed);
         err_count++;
      end
   endtask

   task automatic check_syndromes(input string label);
      for (int i = 0; i < rs_syndrome_pkg::NUM_SYNDROMES; i++) begin
         if (syndromes[i] !== expected[i]) begin
            $display("ERR t=%0t syndromes[%0d] expected %h got %h (%s)",
                     $time, i, expected[i], syndromes[i], label);
            err_count++;
         end
      end
   endtask

   task automatic fill_random();
      for (int j = 0; j < rs_syndrome_pkg::BLOCK_LEN; j++) begin
         block[j] = rs_syndrome_pkg::GF_WIDTH'($random(seed));
      end
   endtask

   //--------------------------------------------------------------------------
   // block driver
   //--------------------------------------------------------------------------
   // feeds block[] with sync on symbol 0, then waits for done
   task automatic run_block(input bit use_gaps);
      int gap;
      int waited;
      for (int j = 0; j < rs_syndrome_pkg::BLOCK_LEN; j++) begin
         if (use_gaps && (($unsigned($random(seed)) % 3) == 0)) begin
            gap = 1 + ($unsigned($random(seed)) % 3);
            repeat (gap) begin
               @(posedge CLK);
               enable  <= 1'b0;
               sync    <= 1'b0;
               data_in <= rs_syndrome_pkg::GF_WIDTH'($random(seed));  // junk while stalled
               @(negedge CLK);
               if (j > 0) check_done_low(j);
            end
         end
         @(posedge CLK);
         enable  <= 1'b1;
         sync    <= (j == 0);
         data_in <= block[j];
         @(negedge CLK);
         if (j > 0) check_done_low(j);
      end
      @(posedge CLK);                              // absorbs symbol 54
      enable <= 1'b0;
      sync   <= 1'b0;
      @(negedge CLK);
      waited = 0;
      while (!done && (waited < 8)) begin
         @(negedge CLK);
         waited++;
      end
      if (!done) begin
         $display("done never rose after the last symbol of the block (t=%0t)", $time);
         fail_count++;
      end
      else if (waited != 0) begin
         $display("done rose %0d cycles after the last symbol instead of at once", waited);
         fail_count++;
      end
   endtask

   //--------------------------------------------------------------------------
   // directed tests
   //--------------------------------------------------------------------------
   task automatic test_reset_state();
      @(negedge CLK);
      check_done_low(0);
      for (int i = 0; i < rs_syndrome_pkg::NUM_SYNDROMES; i++) begin
         expected[i] = '0;
      end
      check_syndromes("after reset");
   endtask

   task automatic test_zero_block();
      for (int j = 0; j < rs_syndrome_pkg::BLOCK_LEN; j++) begin
         block[j] = '0;
      end
      for (int i = 0; i < rs_syndrome_pkg::NUM_SYNDROMES; i++) begin
         expected[i] = '0;                         // r(x) = 0 everywhere
      end
      run_block(1'b0);
      check_syndromes("zero block");
   endtask

   task automatic test_random_block(input bit use_gaps);
      fill_random();
      model_syndromes(block, expected);
      run_block(use_gaps);
      check_syndromes(use_gaps ? "random block with gaps" : "random block");
   endtask

   // lone symbol e at pos, S_i = e * alpha^(i*(53-pos))
   task automatic test_single_symbol(input int pos,
                                     input logic [rs_syndrome_pkg::GF_WIDTH-1:0] e);
      for (int j = 0; j < rs_syndrome_pkg::BLOCK_LEN; j++) begin
         block[j] = '0;
      end
      block[pos] = e;
      for (int i = 0; i < rs_syndrome_pkg::NUM_SYNDROMES; i++) begin
         expected[i] = gf_mul(e, gf_alpha_pow(i * (rs_syndrome_pkg::BLOCK_LEN - 1 - pos)));
      end
      run_block(1'b0);
      check_syndromes(pos == 0 ? "single symbol first" : "single symbol last");
   endtask

   // 20 symbols of an abandoned block, then a fresh one
   task automatic test_restart();
      for (int j = 0; j < 20; j++) begin
         @(posedge CLK);
         enable  <= 1'b1;
         sync    <= (j == 0);
         data_in <= rs_syndrome_pkg::GF_WIDTH'($random(seed));
         @(negedge CLK);
         if (j > 0) check_done_low(j);
      end
      test_random_block(1'b0);
   endtask

   //--------------------------------------------------------------------------
   // main sequence
   //--------------------------------------------------------------------------
   initial begin
      seed       = 32'hc6aa4181;
      err_count  = 0;
      fail_count = 0;
      RESET      = 1'b0;
      enable     = 1'b0;
      sync       = 1'b0;
      data_in    = '0;
      repeat (16) @(posedge CLK);
      RESET <= 1'b1;

      test_reset_state();
      test_random_block(1'b0);
      test_zero_block();                           // must clear the random result
      test_single_symbol(0, 6'h2d);
      test_single_symbol(rs_syndrome_pkg::BLOCK_LEN - 1, 6'h17);
      test_random_block(1'b1);
      test_restart();

      $display("errors: %0d value mismatches, %0d other failures", err_count, fail_count);
      if ((err_count == 0) && (fail_count == 0)) begin
         $display("TB PASSED");
      end
      else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule : tb_rs_syndrome

`default_nettype wire

// ==== filelist.f ====
+incdir+include
src/rs_syndrome_pkg.sv
src/block_counter.sv
src/syndrome_cell.sv
src/rs_syndrome.sv
testbench/tb_rs_syndrome.sv
